/* rtl/stream_mux_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Shared types and sizes for the four-lane packet stream merger.
// Referenced by scoped name from the arbiter, the beat buffer and the top level.
// ~~~~~~~~~~~~~~~~~~~~

package stream_mux_pkg;

   localparam int DATA_WIDTH = 64;  // one beat payload word
   localparam int NUM_LANES  = 4;   // input streams merged
   localparam int FIFO_DEPTH = 16;  // output buffer entries

   // one beat on any stream link
   typedef struct packed {
      logic [DATA_WIDTH-1:0] data;
      logic                  last;  // closes the packet
   } beat_t;

   // compile-time arbitration policy
   typedef enum logic {
      ARB_ROUND_ROBIN = 1'b0,  // ascending scan with a bubble on wrap
      ARB_PRIORITY    = 1'b1   // lane 0 highest with a bubble after each packet
   } arb_mode_e;

   // Grant state of the arbiter. Each lane state is one-hot on its own bit,
   // so the state value doubles as the per-lane grant mask.
   typedef enum logic [NUM_LANES-1:0] {
      ST_IDLE  = 4'b0000,
      ST_LANE0 = 4'b0001,
      ST_LANE1 = 4'b0010,
      ST_LANE2 = 4'b0100,
      ST_LANE3 = 4'b1000
   } arb_state_e;

endpackage

/* rtl/packet_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Per-packet arbiter for four input streams. Grants one lane at a time and
// steers its beats to a single output until the lane's last beat transfers.
// MODE picks round-robin or fixed priority with lane 0 highest.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module packet_arbiter #(
   parameter stream_mux_pkg::arb_mode_e MODE = stream_mux_pkg::ARB_ROUND_ROBIN
) (
   input  logic                                               clk,
   input  logic                                               i_reset,
   input  logic                                               i_clear,
   input  stream_mux_pkg::beat_t [stream_mux_pkg::NUM_LANES-1:0] i_lane_beat,
   input  logic [stream_mux_pkg::NUM_LANES-1:0]               i_lane_valid,
   output logic [stream_mux_pkg::NUM_LANES-1:0]               o_lane_ready,
   output stream_mux_pkg::beat_t                              o_beat,
   output logic                                               o_valid,
   input  logic                                               i_ready
);

   stream_mux_pkg::arb_state_e                state;
   stream_mux_pkg::arb_state_e                next_state;
   stream_mux_pkg::arb_state_e                pick_state;   // lane the scan lands on
   logic [stream_mux_pkg::NUM_LANES-1:0]      grant;        // state as a plain mask
   logic [stream_mux_pkg::NUM_LANES-1:0]      above_mask;   // lanes above the granted one
   logic [stream_mux_pkg::NUM_LANES-1:0]      candidates;
   logic [stream_mux_pkg::NUM_LANES-1:0]      lowest;
   logic                                      last_xfer;

   assign grant = state;

   // Lanes strictly above the granted one. Shifting the one-hot grant left
   // and subtracting one gives the mask of the granted lane and everything
   // below it; lane 3 shifts out, so nothing lies above it.
   assign above_mask = ~((grant << 1) - 1'b1);

   // from idle every lane competes, otherwise only the higher ones
   assign candidates = (state == stream_mux_pkg::ST_IDLE) ? i_lane_valid
                                                          : (i_lane_valid & above_mask);

   // lowest set bit or zero when no lane is waiting
   assign lowest     = candidates & (~candidates + 1'b1);
   assign pick_state = stream_mux_pkg::arb_state_e'(lowest);

   assign last_xfer = o_valid & i_ready & o_beat.last;  // packet ends on this edge

   always_comb
   begin
      next_state = state;
      if (state == stream_mux_pkg::ST_IDLE)
      begin
         next_state = pick_state;  // ST_IDLE again if nothing is valid
      end
      else if (last_xfer)
      begin
         if (MODE == stream_mux_pkg::ARB_PRIORITY)
         begin
            next_state = stream_mux_pkg::ST_IDLE;  // rearbitrate from lane 0
         end
         else
         begin
            next_state = pick_state;  // direct handoff or wrap through idle
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (i_reset || i_clear)
      begin
         state <= stream_mux_pkg::ST_IDLE;
      end
      else
      begin
         state <= next_state;
      end
   end

   // granted lane sees the downstream ready and all others are held off
   assign o_lane_ready = grant & {stream_mux_pkg::NUM_LANES{i_ready}};

   assign o_valid = |(grant & i_lane_valid);

   always_comb
   begin
      o_beat = '0;
      for (int i = 0; i < stream_mux_pkg::NUM_LANES; i++)
      begin
         if (grant[i])
         begin
            o_beat = i_lane_beat[i];  // at most one grant bit is set
         end
      end
   end

endmodule

/* rtl/beat_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Short synchronous FIFO for beats with valid/ready on both sides.
// A write shows at the output in the next cycle, and a full buffer still
// takes a new beat when its head is read in the same cycle.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module beat_fifo #(
   parameter int DEPTH = stream_mux_pkg::FIFO_DEPTH  // power of two
) (
   input  logic                  clk,
   input  logic                  i_reset,
   input  logic                  i_clear,
   input  stream_mux_pkg::beat_t i_beat,
   input  logic                  i_valid,
   output logic                  o_ready,
   output stream_mux_pkg::beat_t o_beat,
   output logic                  o_valid,
   input  logic                  i_ready
);

   localparam int ADDR_WIDTH = $clog2(DEPTH);

   stream_mux_pkg::beat_t   mem [DEPTH];
   logic [ADDR_WIDTH-1:0]   wr_ptr;
   logic [ADDR_WIDTH-1:0]   rd_ptr;
   logic [ADDR_WIDTH:0]     count;  // entries held from 0 to DEPTH
   logic                    full;
   logic                    empty;
   logic                    wr_en;
   logic                    rd_en;

   assign full  = (count == (ADDR_WIDTH + 1)'(DEPTH));
   assign empty = (count == '0);

   // when full, room appears only if the head leaves this cycle
   assign o_ready = ~full | i_ready;
   assign o_valid = ~empty;
   assign o_beat  = mem[rd_ptr];  // head of queue

   assign wr_en = i_valid & o_ready;
   assign rd_en = o_valid & i_ready;

   // beat storage
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_ptr] <= i_beat;
      end
   end

   always_ff @(posedge clk)
   begin
      if (i_reset || i_clear)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (wr_en)
         begin
            wr_ptr <= wr_ptr + 1'b1;  // wraps at DEPTH
         end
         if (rd_en)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Occupancy follows the net of this cycle's write and read. A write and
   // a read together leave it unchanged, full or not.
   always_ff @(posedge clk)
   begin
      if (i_reset || i_clear)
      begin
         count <= '0;
      end
      else
      begin
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

/* rtl/stream_mux_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Four-lane packet stream merger. The arbiter picks whole packets and the
// beat FIFO decouples the merged stream from the downstream receiver.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module stream_mux_top #(
   parameter stream_mux_pkg::arb_mode_e MODE = stream_mux_pkg::ARB_ROUND_ROBIN
) (
   input  logic                                               clk,
   input  logic                                               i_reset,
   input  logic                                               i_clear,
   input  stream_mux_pkg::beat_t [stream_mux_pkg::NUM_LANES-1:0] i_lane_beat,
   input  logic [stream_mux_pkg::NUM_LANES-1:0]               i_lane_valid,
   output logic [stream_mux_pkg::NUM_LANES-1:0]               o_lane_ready,
   output stream_mux_pkg::beat_t                              o_beat,
   output logic                                               o_valid,
   input  logic                                               i_ready
);

   stream_mux_pkg::beat_t arb_beat;   // merged stream into the buffer
   logic                  arb_valid;
   logic                  arb_ready;  // buffer has room

   packet_arbiter #(
      .MODE (MODE)
   ) u_packet_arbiter (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_clear      (i_clear),
      .i_lane_beat  (i_lane_beat),
      .i_lane_valid (i_lane_valid),
      .o_lane_ready (o_lane_ready),
      .o_beat       (arb_beat),
      .o_valid      (arb_valid),
      .i_ready      (arb_ready)
   );

   beat_fifo #(
      .DEPTH (stream_mux_pkg::FIFO_DEPTH)
   ) u_beat_fifo (
      .clk     (clk),
      .i_reset (i_reset),
      .i_clear (i_clear),
      .i_beat  (arb_beat),
      .i_valid (arb_valid),
      .o_ready (arb_ready),
      .o_beat  (o_beat),
      .o_valid (o_valid),
      .i_ready (i_ready)
   );

endmodule

/* verification/lane_source.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Testbench packet source for one input lane of the stream merger.
// Sends numbered packets of 1 to 8 beats and holds each beat until it transfers.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module lane_source #(
   parameter int          LANE        = 0,
   parameter int          NUM_PACKETS = 16,
   parameter logic [31:0] SEED        = 32'h0
) (
   input  logic                  clk,
   input  logic                  i_reset,
   input  logic                  i_pause,  // no new packet starts while high
   input  logic                  i_ready,
   output stream_mux_pkg::beat_t o_beat,
   output logic                  o_valid,
   output logic                  o_done
);

   integer seed;
   int     sent;        // packets fully transferred and number of the current one
   int     beat_idx;
   int     packet_len;
   logic   active;      // a packet is on the lane

   // lane in the top byte, then packet number, packet length and beat index
   function automatic logic [stream_mux_pkg::DATA_WIDTH-1:0] beat_data(
      input int pkt,
      input int idx,
      input int len
   );
      return {8'(LANE), 24'(pkt), 16'(len), 16'(idx)};
   endfunction

   initial
   begin
      seed = SEED;
      o_beat  <= '0;
      o_valid <= 1'b0;
      o_done  <= 1'b0;
   end

   always @(posedge clk)
   begin
      if (i_reset)
      begin
         sent       = 0;
         beat_idx   = 0;
         packet_len = 0;
         active     = 1'b0;
         o_valid    <= 1'b0;
         o_done     <= 1'b0;
      end
      else
      begin
         if (o_valid && i_ready)
         begin
            if (o_beat.last)
            begin
               sent     = sent + 1;
               beat_idx = 0;
               active   = 1'b0;
            end
            else
            begin
               beat_idx = beat_idx + 1;
            end
         end
         if (!active && !i_pause && sent < NUM_PACKETS)
         begin
            packet_len = 1 + ($unsigned($random(seed)) % 8);  // 1 to 8 beats
            active     = 1'b1;
         end
         o_valid     <= active;  // back-to-back packets keep valid high
         o_beat.data <= beat_data(sent, beat_idx, packet_len);
         o_beat.last <= (beat_idx == packet_len - 1);
         o_done      <= !active && (sent >= NUM_PACKETS);
      end
   end

endmodule

/* verification/tb_stream_mux.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the four-lane stream merger. Runs one DUT per arbitration
// mode on the same stimulus and checks integrity, grant order and flow control.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_stream_mux;

   localparam int          NUM_PACKETS = 24;  // per lane
   localparam logic [31:0] SEED        = 32'hc157c4f1;
   localparam int          FILL_LIMIT  = 400;
   localparam int          DONE_LIMIT  = 20000;
   localparam int          DRAIN_LIMIT = 400;

   logic   clk;
   logic   reset;
   logic   clear;
   logic   ready;       // downstream ready, shared by both copies
   logic   pause;
   logic   hold_stall;  // forces ready low
   integer seed = SEED;
   int     phase_left = 0;
   int     phase_kind = 0;
   int     data_errors = 0;
   int     order_errors = 0;
   int     control_errors = 0;
   int     timeout_errors = 0;

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // -1 when no lane above the given one is set
   function automatic int lowest_valid_above(
      input logic [stream_mux_pkg::NUM_LANES-1:0] mask,
      input int                                   after
   );
      int found;
      found = -1;
      for (int i = stream_mux_pkg::NUM_LANES - 1; i > after; i--)
      begin
         if (mask[i])
            found = i;
      end
      return found;
   endfunction

   // downstream ready in random phases of free flow, stall and toggling
   always @(posedge clk)
   begin
      if (reset || hold_stall)
      begin
         ready <= 1'b0;
      end
      else
      begin
         if (phase_left == 0)
         begin
            phase_left = 1 + ($unsigned($random(seed)) % 32);
            phase_kind = $unsigned($random(seed)) % 3;
         end
         phase_left = phase_left - 1;
         case (phase_kind)
            0:       ready <= 1'b1;
            1:       ready <= 1'b0;
            default: ready <= (($random(seed) & 32'h1) != 0);
         endcase
      end
   end

   for (genvar m = 0; m < 2; m++)
   begin : gen_mode
      localparam stream_mux_pkg::arb_mode_e MODE =
         (m == 0) ? stream_mux_pkg::ARB_ROUND_ROBIN : stream_mux_pkg::ARB_PRIORITY;

      wire stream_mux_pkg::beat_t [stream_mux_pkg::NUM_LANES-1:0] lane_beat;
      wire [stream_mux_pkg::NUM_LANES-1:0]  lane_valid;
      wire [stream_mux_pkg::NUM_LANES-1:0]  lane_done;
      logic [stream_mux_pkg::NUM_LANES-1:0] lane_ready;
      stream_mux_pkg::beat_t                out_beat;
      logic                                 out_valid;
      stream_mux_pkg::beat_t                expect_q [stream_mux_pkg::NUM_LANES][$];
      int                                   buffered;    // beats the DUT should hold
      int                                   grant_lane;  // -1 while idle
      int                                   pkt_lane;    // -1 between output packets
      int                                   fill_level;
      int                                   open_lane;

      for (genvar l = 0; l < stream_mux_pkg::NUM_LANES; l++)
      begin : gen_lane
         lane_source #(
            .LANE        (l),
            .NUM_PACKETS (NUM_PACKETS),
            .SEED        (SEED + l)
         ) u_lane_source (
            .clk     (clk),
            .i_reset (reset),
            .i_pause (pause),
            .i_ready (lane_ready[l]),
            .o_beat  (lane_beat[l]),
            .o_valid (lane_valid[l]),
            .o_done  (lane_done[l])
         );
      end

      stream_mux_top #(
         .MODE (MODE)
      ) u_stream_mux_top (
         .clk          (clk),
         .i_reset      (reset),
         .i_clear      (clear),
         .i_lane_beat  (lane_beat),
         .i_lane_valid (lane_valid),
         .o_lane_ready (lane_ready),
         .o_beat       (out_beat),
         .o_valid      (out_valid),
         .i_ready      (ready)
      );

      always @(posedge clk)
      begin : check_proc
         logic [stream_mux_pkg::NUM_LANES-1:0] xfer;
         logic [stream_mux_pkg::NUM_LANES-1:0] exp_ready;
         stream_mux_pkg::beat_t                exp_beat;
         int                                   lane;
         if (reset || clear)
         begin
            grant_lane = -1;  // clear also drops everything in flight
            pkt_lane   = -1;
            buffered   = 0;
            for (int i = 0; i < stream_mux_pkg::NUM_LANES; i++)
               expect_q[i].delete();
         end
         else
         begin
            xfer = lane_valid & lane_ready;
            // only the granted lane, and only while the buffer can take a beat
            exp_ready = '0;
            if (grant_lane >= 0 && (buffered < stream_mux_pkg::FIFO_DEPTH || ready))
               exp_ready[grant_lane] = 1'b1;
            assert (lane_ready == exp_ready) else
            begin
               $display("FAILED lane_ready mode %0d expected %b actual %b",
                        m, exp_ready, lane_ready);
               order_errors++;
            end
            assert (out_valid == (buffered != 0)) else
            begin
               $display("FAILED out_valid mode %0d expected %b actual %b",
                        m, (buffered != 0), out_valid);
               control_errors++;
            end
            if (out_valid && ready)
            begin
               lane     = out_beat.data[stream_mux_pkg::DATA_WIDTH-1 -: 8];
               buffered = buffered - 1;
               if (lane >= stream_mux_pkg::NUM_LANES || expect_q[lane].size() == 0)
               begin
                  $display("mode %0d sent beat %h while no beat of its lane was pending",
                           m, out_beat);
                  data_errors++;
               end
               else
               begin
                  exp_beat = expect_q[lane].pop_front();
                  assert (out_beat == exp_beat) else
                  begin
                     $display("FAILED integrity mode %0d expected %h actual %h",
                              m, exp_beat, out_beat);
                     data_errors++;
                  end
               end
               if (pkt_lane >= 0)
               begin
                  assert (lane == pkt_lane) else
                  begin
                     $display("FAILED interleave mode %0d expected lane %0d actual lane %0d",
                              m, pkt_lane, lane);
                     order_errors++;
                  end
               end
               if (out_beat.last)
                  pkt_lane = -1;
               else if (pkt_lane < 0)
                  pkt_lane = lane;
            end
            for (int i = 0; i < stream_mux_pkg::NUM_LANES; i++)
            begin
               if (xfer[i])
               begin
                  expect_q[i].push_back(lane_beat[i]);
                  buffered = buffered + 1;
               end
            end
            assert (buffered <= stream_mux_pkg::FIFO_DEPTH) else
            begin
               $display("mode %0d accepted more beats than the output buffer holds", m);
               control_errors++;
            end
            // grant goes from idle to the lowest valid lane and moves upward in round-robin
            if (grant_lane < 0)
               grant_lane = lowest_valid_above(lane_valid, -1);
            else if (xfer[grant_lane] && lane_beat[grant_lane].last)
            begin
               if (MODE == stream_mux_pkg::ARB_PRIORITY)
                  grant_lane = -1;
               else
                  grant_lane = lowest_valid_above(lane_valid, grant_lane);
            end
         end
         fill_level <= buffered;
         open_lane  <= pkt_lane;
      end
   end

   task automatic wait_buffers_full();
      int cycles;
      cycles = 0;
      while (!(gen_mode[0].fill_level == stream_mux_pkg::FIFO_DEPTH &&
               gen_mode[1].fill_level == stream_mux_pkg::FIFO_DEPTH) && cycles < FILL_LIMIT)
      begin
         @(posedge clk);
         cycles++;
      end
      if (cycles >= FILL_LIMIT)
      begin
         $display("timeout: the output buffers never filled while ready was held low");
         timeout_errors++;
      end
   endtask

   task automatic wait_sources_done();
      int cycles;
      cycles = 0;
      while (!(&gen_mode[0].lane_done && &gen_mode[1].lane_done) && cycles < DONE_LIMIT)
      begin
         @(posedge clk);
         cycles++;
      end
      if (cycles >= DONE_LIMIT)
      begin
         $display("timeout: the lane sources did not get all their packets accepted");
         timeout_errors++;
      end
   endtask

   task automatic wait_buffers_drained();
      int cycles;
      cycles = 0;
      while (!(gen_mode[0].fill_level == 0 && gen_mode[1].fill_level == 0) &&
             cycles < DRAIN_LIMIT)
      begin
         @(posedge clk);
         cycles++;
      end
      if (cycles >= DRAIN_LIMIT)
      begin
         $display("timeout: accepted beats never left the merger");
         timeout_errors++;
      end
   endtask

   task automatic check_end_state(input int mode, input int lane);
      assert (lane == -1) else
      begin
         $display("FAILED end_of_run mode %0d expected open lane -1 actual %0d", mode, lane);
         order_errors++;
      end
   endtask

   task automatic finish_run();
      $display("error counts: data %0d, order %0d, control %0d, timeout %0d",
               data_errors, order_errors, control_errors, timeout_errors);
      if (data_errors + order_errors + control_errors + timeout_errors == 0)
      begin
         $display("No errors");
      end
      else
      begin
         $display("Errors found");
      end
      $finish;
   endtask

   initial
   begin
      reset      <= 1'b1;
      clear      <= 1'b0;
      ready      <= 1'b0;
      pause      <= 1'b1;
      hold_stall <= 1'b1;
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      repeat (4) @(posedge clk);  // no input yet so outputs stay low
      pause <= 1'b0;
      wait_buffers_full();
      repeat (8) @(posedge clk);  // buffer full while downstream stays stalled
      clear <= 1'b1;
      @(posedge clk);
      clear <= 1'b0;
      repeat (4) @(posedge clk);
      hold_stall <= 1'b0;
      wait_sources_done();
      wait_buffers_drained();
      check_end_state(0, gen_mode[0].open_lane);
      check_end_state(1, gen_mode[1].open_lane);
      finish_run();
   end

endmodule

/* sources.f */
rtl/stream_mux_pkg.sv
rtl/packet_arbiter.sv
rtl/beat_fifo.sv
rtl/stream_mux_top.sv
verification/lane_source.sv
verification/tb_stream_mux.sv

/* Bender.yml */
package:
  name: stream_mux

sources:
  # design, package first
  - rtl/stream_mux_pkg.sv
  - rtl/packet_arbiter.sv
  - rtl/beat_fifo.sv
  - rtl/stream_mux_top.sv
  # testbench
  - target: test
    files:
      - verification/lane_source.sv
      - verification/tb_stream_mux.sv
